/* filelist.f */
+incdir+sim
design/seq_ctrl_pkg.sv
design/ir_field_decode.sv
design/sequence_fsm.sv
design/control_encoder.sv
design/sequence_control.sv
sim/tb_sequence_control.sv

/* Bender.yml */
package:
  name: sequence_control

sources:
  - design/seq_ctrl_pkg.sv
  - design/ir_field_decode.sv
  - design/sequence_fsm.sv
  - design/control_encoder.sv
  - design/sequence_control.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_sequence_control.sv

/* sim/seq_vectors.svh */
// Columns: name, opcode, IR bit 10, zero flag, cycles from fetch to next fetch
//   then decode cycle: pc_ld, pc_src, stk_ld, reg_we, data_src, alu_ld, flg_ld,
//   flg_rst, alu_op, out_ld
task automatic load_vectors();
    // ALU group, write-back in the third cycle
    add_row("ADD", seq_ctrl_pkg::OP_ADD, 1'b1, 1'b0, 3,
            1'b0, seq_ctrl_pkg::PC_SRC_IDLE, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b1, 1'b1, 1'b0, seq_ctrl_pkg::OP_ADD, 1'b0);
    add_row("SUB", seq_ctrl_pkg::OP_SUB, 1'b0, 1'b0, 3,
            1'b0, seq_ctrl_pkg::PC_SRC_IDLE, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b1, 1'b1, 1'b0, seq_ctrl_pkg::OP_SUB, 1'b0);
    add_row("SHL", seq_ctrl_pkg::OP_SHL, 1'b1, 1'b1, 3,  // Bit 10 ignored here
            1'b0, seq_ctrl_pkg::PC_SRC_IDLE, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b1, 1'b1, 1'b0, seq_ctrl_pkg::OP_SHL, 1'b0);
    add_row("SHR", seq_ctrl_pkg::OP_SHR, 1'b0, 1'b1, 3,
            1'b0, seq_ctrl_pkg::PC_SRC_IDLE, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b1, 1'b1, 1'b0, seq_ctrl_pkg::OP_SHR, 1'b0);
    add_row("CMP", seq_ctrl_pkg::OP_SUB, 1'b1, 1'b1, 2,  // SUB without destination
            1'b0, seq_ctrl_pkg::PC_SRC_IDLE, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b1, 1'b1, 1'b0, seq_ctrl_pkg::OP_SUB, 1'b0);
    // Branch and flow, empty settle cycle after the PC load
    add_row("BNE_TAKEN", seq_ctrl_pkg::OP_BNE, 1'b0, 1'b0, 3,
            1'b1, seq_ctrl_pkg::PC_SRC_BRANCH, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b0, 1'b0, 1'b1, seq_ctrl_pkg::ALU_OP_NONE, 1'b0);
    add_row("BNE_NOT_TAKEN", seq_ctrl_pkg::OP_BNE, 1'b1, 1'b1, 2,
            1'b0, seq_ctrl_pkg::PC_SRC_IDLE, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b0, 1'b0, 1'b0, seq_ctrl_pkg::ALU_OP_NONE, 1'b0);
    add_row("JMP", seq_ctrl_pkg::OP_JMP, 1'b0, 1'b0, 3,
            1'b1, seq_ctrl_pkg::PC_SRC_REG_SRC1, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b0, 1'b0, 1'b0, seq_ctrl_pkg::ALU_OP_NONE, 1'b0);
    add_row("JPL", seq_ctrl_pkg::OP_JPL, 1'b1, 1'b1, 3,
            1'b1, seq_ctrl_pkg::PC_SRC_REG_SRC1, 1'b1, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b0, 1'b0, 1'b0, seq_ctrl_pkg::ALU_OP_NONE, 1'b0);
    add_row("RET", seq_ctrl_pkg::OP_RET, 1'b0, 1'b1, 3,
            1'b1, seq_ctrl_pkg::PC_SRC_STACK, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b0, 1'b0, 1'b0, seq_ctrl_pkg::ALU_OP_NONE, 1'b0);
    // Two-cycle group
    add_row("LDI", seq_ctrl_pkg::OP_LDI, 1'b0, 1'b0, 2,
            1'b0, seq_ctrl_pkg::PC_SRC_IDLE, 1'b0, 1'b1, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b0, 1'b0, 1'b0, seq_ctrl_pkg::ALU_OP_NONE, 1'b0);
    add_row("OTR", seq_ctrl_pkg::OP_OTR, 1'b1, 1'b0, 2,
            1'b0, seq_ctrl_pkg::PC_SRC_IDLE, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b0, 1'b0, 1'b0, seq_ctrl_pkg::ALU_OP_NONE, 1'b1);
    add_row("NOP", seq_ctrl_pkg::OP_NOP, 1'b0, 1'b1, 2,
            1'b0, seq_ctrl_pkg::PC_SRC_IDLE, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b0, 1'b0, 1'b0, seq_ctrl_pkg::ALU_OP_NONE, 1'b0);
    add_row("UNLISTED", 4'd13, 1'b1, 1'b0, 2,  // Behaves as NOP
            1'b0, seq_ctrl_pkg::PC_SRC_IDLE, 1'b0, 1'b0, seq_ctrl_pkg::DATA_SRC_ZEXT,
            1'b0, 1'b0, 1'b0, seq_ctrl_pkg::ALU_OP_NONE, 1'b0);
endtask

/* sim/tb_sequence_control.sv */
`timescale 1ns/1ps

module tb_sequence_control;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int WAIT_LIMIT   = 16;  // Cycles before a wait gives up
    localparam int HALT_CYCLES  = 20;

    // All control and status outputs in top-level port order
    typedef struct packed {
        logic       stk_ld;
        logic       ir_ld;
        logic       pc_ld;
        logic       pc_inc;
        logic [2:0] pc_src;
        logic       reg_we;
        logic [1:0] data_src;
        logic [3:0] alu_op;
        logic       alu_ld;
        logic       flg_ld;
        logic       flg_rst;
        logic       out_ld;
        logic       ready;
        logic       halt;
    } ctrl_t;

    typedef struct {
        string      name;
        logic [3:0] opcode;
        logic       ignore_dest;  // IR bit 10
        logic       zero;         // Zero flag for BNE
        int         cycles;       // Fetch to next fetch
        ctrl_t      dec;          // Decode cycle outputs
    } vec_row_t;

    logic                    clk_i;
    logic                    resetComplete;
    logic [15:0]             ir_i;
    logic [3:0]              alu_flags_i;
    logic                    stk_ld_o;
    logic                    ir_ld_o;
    logic                    pc_ld_o;
    logic                    pc_inc_o;
    logic                    reg_we_o;
    logic                    alu_ld_o;
    logic                    flg_ld_o;
    logic                    flg_rst_o;
    logic                    out_ld_o;
    logic                    ready_o;
    logic                    halt_o;
    seq_ctrl_pkg::pc_src_t   pc_src_o;
    seq_ctrl_pkg::data_src_t data_src_o;
    logic [3:0]              alu_op_o;
    ctrl_t                   actual;  // DUT outputs gathered for compare

    vec_row_t rows[$];
    int       checks = 0;
    int       mismatches = 0;
    int       timeouts = 0;

    sequence_control sequence_control_inst (.*);

    assign actual = {stk_ld_o, ir_ld_o, pc_ld_o, pc_inc_o, pc_src_o, reg_we_o, data_src_o,
                     alu_op_o, alu_ld_o, flg_ld_o, flg_rst_o, out_ld_o, ready_o, halt_o};

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Everything inactive with ready as given
    function automatic ctrl_t inactive_ctrl(input logic ready);
        ctrl_t c;
        c          = '0;
        c.pc_src   = seq_ctrl_pkg::PC_SRC_IDLE;
        c.data_src = seq_ctrl_pkg::DATA_SRC_ZEXT;
        c.alu_op   = seq_ctrl_pkg::ALU_OP_NONE;
        c.ready    = ready;
        return c;
    endfunction

    function automatic ctrl_t fetch_ctrl();
        ctrl_t c;
        c        = inactive_ctrl(1'b1);
        c.ir_ld  = 1'b1;
        c.pc_inc = 1'b1;
        return c;
    endfunction

    task automatic add_row(input string name, input logic [3:0] opcode,
                           input logic ignore_dest, input logic zero, input int cycles,
                           input logic pc_ld, input logic [2:0] pc_src, input logic stk_ld,
                           input logic reg_we, input logic [1:0] data_src,
                           input logic alu_ld, input logic flg_ld, input logic flg_rst,
                           input logic [3:0] alu_op, input logic out_ld);
        vec_row_t r;
        r.name         = name;
        r.opcode       = opcode;
        r.ignore_dest  = ignore_dest;
        r.zero         = zero;
        r.cycles       = cycles;
        r.dec          = inactive_ctrl(1'b1);  // Ready while running
        r.dec.pc_ld    = pc_ld;
        r.dec.pc_src   = pc_src;
        r.dec.stk_ld   = stk_ld;
        r.dec.reg_we   = reg_we;
        r.dec.data_src = data_src;
        r.dec.alu_ld   = alu_ld;
        r.dec.flg_ld   = flg_ld;
        r.dec.flg_rst  = flg_rst;
        r.dec.alu_op   = alu_op;
        r.dec.out_ld   = out_ld;
        rows.push_back(r);
    endtask

    `include "seq_vectors.svh"

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] got);
        checks++;
        if (got !== expected) begin
            mismatches++;
            $display("MISMATCH %s: expected %0h, actual %0h", test, expected, got);
        end
    endtask

    // Waits on falling edges for the outputs and counts the cycles in n
    task automatic wait_for_ctrl(input string test, input ctrl_t target, output int n);
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (actual !== target && n < WAIT_LIMIT);
        if (actual !== target) begin
            timeouts++;
            $display("TIMEOUT in %s: expected outputs not seen within %0d cycles",
                     test, WAIT_LIMIT);
        end
    endtask

    task automatic hold_reset();
        resetComplete <= 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk_i);
        @(negedge clk_i);
        check_value("in reset", inactive_ctrl(1'b0), actual);
        @(posedge clk_i);
        resetComplete <= 1'b0;  // Fifth edge still sees reset
    endtask

    // --------------------------------------------------------------------------
    // Reset vector, ready, first fetch
    // --------------------------------------------------------------------------
    task automatic check_vector_sequence(input string test);
        ctrl_t exp;
        int    n;
        @(negedge clk_i);
        check_value({test, " idle after reset"}, inactive_ctrl(1'b0), actual);
        exp        = inactive_ctrl(1'b0);
        exp.pc_ld  = 1'b1;
        exp.pc_src = seq_ctrl_pkg::PC_SRC_RESET_VEC;
        wait_for_ctrl({test, " vector load"}, exp, n);
        check_value({test, " vector load delay"}, 1, n);
        @(negedge clk_i);
        exp       = inactive_ctrl(1'b0);
        exp.ir_ld = 1'b1;
        check_value({test, " vector IR"}, exp, actual);
        @(negedge clk_i);
        exp        = inactive_ctrl(1'b0);
        exp.pc_ld  = 1'b1;
        exp.pc_src = seq_ctrl_pkg::PC_SRC_ZEXT;
        check_value({test, " vector jump"}, exp, actual);
        @(negedge clk_i);
        check_value({test, " ready"}, inactive_ctrl(1'b1), actual);
        @(negedge clk_i);
        check_value({test, " first fetch"}, fetch_ctrl(), actual);
    endtask

    // Starts and ends on the falling edge of a fetch cycle
    task automatic run_row(input vec_row_t row);
        ctrl_t       exp;
        logic [15:0] word;
        logic [3:0]  flags;
        int          n;
        int          elapsed;
        word                                      = 16'($urandom);
        word[15 -: 4]                             = row.opcode;
        word[seq_ctrl_pkg::IGNORE_DEST_BIT]       = row.ignore_dest;
        flags                                     = 4'($urandom);  // Carry, neg, overflow
        flags[0]                                  = row.zero;
        @(posedge clk_i);
        ir_i        <= word;
        alu_flags_i <= flags;
        @(negedge clk_i);
        check_value({row.name, " decode"}, row.dec, actual);
        elapsed = 2;
        if (row.cycles == 3) begin
            exp = inactive_ctrl(1'b1);  // Settle cycle
            if (row.dec.alu_ld) begin
                exp.reg_we   = 1'b1;    // Write-back
                exp.data_src = seq_ctrl_pkg::DATA_SRC_ALU;
            end
            @(negedge clk_i);
            check_value({row.name, " third cycle"}, exp, actual);
            elapsed = 3;
        end
        wait_for_ctrl({row.name, " next fetch"}, fetch_ctrl(), n);
        check_value({row.name, " cycle count"}, row.cycles, elapsed + n - 1);
    endtask

    task automatic check_halt();
        ctrl_t exp;
        @(posedge clk_i);
        ir_i        <= {seq_ctrl_pkg::OP_HLT, 12'($urandom)};
        alu_flags_i <= 4'($urandom);
        @(negedge clk_i);
        check_value("HLT decode", inactive_ctrl(1'b1), actual);
        exp      = inactive_ctrl(1'b0);
        exp.halt = 1'b1;
        for (int i = 0; i < HALT_CYCLES; i++) begin
            @(negedge clk_i);
            check_value("HLT halted", exp, actual);  // Also no fetch
        end
    endtask

    initial begin
        int unsigned rng_seed;
        rng_seed      = 32'h781e_61dc;
        resetComplete = 1'b1;
        ir_i          = '0;
        alu_flags_i   = '0;
        void'($urandom(rng_seed));
        load_vectors();
        hold_reset();
        check_vector_sequence("power-up");
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        check_halt();
        @(posedge clk_i);
        hold_reset();  // Only way out of halt
        check_vector_sequence("restart");
        run_row(rows[0]);
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* design/sequence_control.sv */
`timescale 1ns/1ps

module sequence_control (
    input  logic                                  clk_i,
    input  logic                                  resetComplete,
    input  logic [seq_ctrl_pkg::DATA_WIDTH-1:0]   ir_i,
    input  logic [seq_ctrl_pkg::FLAG_COUNT-1:0]   alu_flags_i,
    output logic                                  stk_ld_o,
    output logic                                  ir_ld_o,
    output logic                                  pc_ld_o,
    output logic                                  pc_inc_o,
    output seq_ctrl_pkg::pc_src_t                 pc_src_o,
    output logic                                  reg_we_o,
    output seq_ctrl_pkg::data_src_t               data_src_o,
    output logic [seq_ctrl_pkg::OPCODE_WIDTH-1:0] alu_op_o,
    output logic                                  alu_ld_o,
    output logic                                  flg_ld_o,
    output logic                                  flg_rst_o,
    output logic                                  out_ld_o,
    output logic                                  ready_o,
    output logic                                  halt_o
);

    seq_ctrl_pkg::instr_class_t            instr_class;  // Decoder to FSM
    logic [seq_ctrl_pkg::OPCODE_WIDTH-1:0] dec_alu_op;   // Decoder to encoder
    seq_ctrl_pkg::seq_step_t               step;         // FSM to encoder

    ir_field_decode ir_field_decode_inst (
        .ir_i          (ir_i),
        .alu_flags_i   (alu_flags_i),
        .instr_class_o (instr_class),
        .alu_op_o      (dec_alu_op)
    );

    sequence_fsm sequence_fsm_inst (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .instr_class_i (instr_class),
        .step_o        (step)
    );

    control_encoder control_encoder_inst (
        .step_i     (step),
        .alu_op_i   (dec_alu_op),
        .stk_ld_o   (stk_ld_o),
        .ir_ld_o    (ir_ld_o),
        .pc_ld_o    (pc_ld_o),
        .pc_inc_o   (pc_inc_o),
        .pc_src_o   (pc_src_o),
        .reg_we_o   (reg_we_o),
        .data_src_o (data_src_o),
        .alu_op_o   (alu_op_o),
        .alu_ld_o   (alu_ld_o),
        .flg_ld_o   (flg_ld_o),
        .flg_rst_o  (flg_rst_o),
        .out_ld_o   (out_ld_o),
        .ready_o    (ready_o),
        .halt_o     (halt_o)
    );

endmodule

/* design/control_encoder.sv */
`timescale 1ns/1ps

module control_encoder (
    input  seq_ctrl_pkg::seq_step_t               step_i,
    input  logic [seq_ctrl_pkg::OPCODE_WIDTH-1:0] alu_op_i,
    output logic                                  stk_ld_o,
    output logic                                  ir_ld_o,
    output logic                                  pc_ld_o,
    output logic                                  pc_inc_o,
    output seq_ctrl_pkg::pc_src_t                 pc_src_o,
    output logic                                  reg_we_o,
    output seq_ctrl_pkg::data_src_t               data_src_o,
    output logic [seq_ctrl_pkg::OPCODE_WIDTH-1:0] alu_op_o,
    output logic                                  alu_ld_o,
    output logic                                  flg_ld_o,
    output logic                                  flg_rst_o,
    output logic                                  out_ld_o,
    output logic                                  ready_o,
    output logic                                  halt_o
);

    always_comb begin
        // Inactive levels
        stk_ld_o   = 1'b0;
        ir_ld_o    = 1'b0;
        pc_ld_o    = 1'b0;
        pc_inc_o   = 1'b0;
        pc_src_o   = seq_ctrl_pkg::PC_SRC_IDLE;
        reg_we_o   = 1'b0;
        data_src_o = seq_ctrl_pkg::DATA_SRC_ZEXT;
        alu_op_o   = seq_ctrl_pkg::ALU_OP_NONE;
        alu_ld_o   = 1'b0;
        flg_ld_o   = 1'b0;
        flg_rst_o  = 1'b0;
        out_ld_o   = 1'b0;
        ready_o    = 1'b1;
        halt_o     = 1'b0;

        case (step_i)
            // ----------------------------------------------------------------
            // Reset and vector sequence
            // ----------------------------------------------------------------
            seq_ctrl_pkg::STEP_IDLE: ready_o = 1'b0;
            seq_ctrl_pkg::STEP_VEC_LOAD: begin
                pc_ld_o  = 1'b1;
                pc_src_o = seq_ctrl_pkg::PC_SRC_RESET_VEC;
                ready_o  = 1'b0;
            end
            seq_ctrl_pkg::STEP_VEC_IR: begin
                ir_ld_o = 1'b1;   // First word from the vector address
                ready_o = 1'b0;
            end
            seq_ctrl_pkg::STEP_VEC_JUMP: begin
                pc_ld_o  = 1'b1;
                pc_src_o = seq_ctrl_pkg::PC_SRC_ZEXT;
                ready_o  = 1'b0;
            end
            // ----------------------------------------------------------------
            // Fetch, decode, execute
            // ----------------------------------------------------------------
            seq_ctrl_pkg::STEP_FETCH: begin
                ir_ld_o  = 1'b1;
                pc_inc_o = 1'b1;  // Bump PC in the same cycle
            end
            seq_ctrl_pkg::STEP_DEC_ALU,
            seq_ctrl_pkg::STEP_DEC_CMP: begin
                alu_op_o = alu_op_i;
                alu_ld_o = 1'b1;
                flg_ld_o = 1'b1;
            end
            seq_ctrl_pkg::STEP_WRITEBACK: begin
                reg_we_o   = 1'b1;
                data_src_o = seq_ctrl_pkg::DATA_SRC_ALU;
            end
            seq_ctrl_pkg::STEP_DEC_BRANCH: begin
                pc_ld_o   = 1'b1;
                pc_src_o  = seq_ctrl_pkg::PC_SRC_BRANCH;
                flg_rst_o = 1'b1;  // Flags consumed by the branch
            end
            seq_ctrl_pkg::STEP_DEC_JMP: begin
                pc_ld_o  = 1'b1;
                pc_src_o = seq_ctrl_pkg::PC_SRC_REG_SRC1;
            end
            seq_ctrl_pkg::STEP_DEC_JPL: begin
                pc_ld_o  = 1'b1;
                pc_src_o = seq_ctrl_pkg::PC_SRC_REG_SRC1;
                stk_ld_o = 1'b1;   // Save return address
            end
            seq_ctrl_pkg::STEP_DEC_RET: begin
                pc_ld_o  = 1'b1;
                pc_src_o = seq_ctrl_pkg::PC_SRC_STACK;
            end
            seq_ctrl_pkg::STEP_DEC_LDI: begin
                reg_we_o   = 1'b1;
                data_src_o = seq_ctrl_pkg::DATA_SRC_ZEXT;  // Immediate low byte
            end
            seq_ctrl_pkg::STEP_DEC_OTR: out_ld_o = 1'b1;
            seq_ctrl_pkg::STEP_HALT: begin
                halt_o  = 1'b1;
                ready_o = 1'b0;
            end
            default: ;  // DEC_NONE, no strobes
        endcase
    end

endmodule

/* design/sequence_fsm.sv */
`timescale 1ns/1ps

module sequence_fsm (
    input  logic                       clk_i,
    input  logic                       resetComplete,
    input  seq_ctrl_pkg::instr_class_t instr_class_i,
    output seq_ctrl_pkg::seq_step_t    step_o
);

    typedef enum logic [2:0] {
        S_RESET,
        S_READY,
        S_FETCH,
        S_DECODE,
        S_ALU_EXEC,     // Destination write-back
        S_BASIC_EXEC,   // Settle cycle after a PC load
        S_HALT
    } main_state_t;

    // Reset-vector sub-state
    typedef enum logic [1:0] {
        V_IDLE,
        V_LOAD,   // PC from reset vector
        V_IR,     // IR from memory
        V_JUMP    // PC from zero-extended IR
    } vec_state_t;

    main_state_t state;
    main_state_t state_next;
    vec_state_t  vec_state;
    vec_state_t  vec_next;

    // ------------------------------------------------------------------------
    // State registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            state     <= S_RESET;
            vec_state <= V_IDLE;
        end else begin
            state     <= state_next;
            vec_state <= vec_next;
        end
    end

    // Next-state logic
    always_comb begin
        state_next = state;
        vec_next   = vec_state;  // Holds outside reset
        case (state)
            S_RESET: begin
                case (vec_state)
                    V_IDLE: vec_next = V_LOAD;
                    V_LOAD: vec_next = V_IR;
                    V_IR:   vec_next = V_JUMP;
                    default: begin
                        vec_next   = V_IDLE;
                        state_next = S_READY;  // Vector sequence done
                    end
                endcase
            end
            S_READY: state_next = S_FETCH;
            S_FETCH: state_next = S_DECODE;
            S_DECODE: begin
                case (instr_class_i)
                    seq_ctrl_pkg::CLS_ALU: state_next = S_ALU_EXEC;
                    seq_ctrl_pkg::CLS_BRANCH_TAKEN,
                    seq_ctrl_pkg::CLS_JMP,
                    seq_ctrl_pkg::CLS_JPL,
                    seq_ctrl_pkg::CLS_RET: state_next = S_BASIC_EXEC;
                    seq_ctrl_pkg::CLS_HLT: state_next = S_HALT;
                    default:               state_next = S_FETCH;  // Two-cycle instructions
                endcase
            end
            S_ALU_EXEC,
            S_BASIC_EXEC: state_next = S_FETCH;
            S_HALT:       state_next = S_HALT;  // Left only by reset
            default: begin
                state_next = S_RESET;
                vec_next   = V_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Action of the current cycle
    // ------------------------------------------------------------------------
    always_comb begin
        step_o = seq_ctrl_pkg::STEP_IDLE;
        case (state)
            S_RESET: begin
                case (vec_state)
                    V_LOAD:  step_o = seq_ctrl_pkg::STEP_VEC_LOAD;
                    V_IR:    step_o = seq_ctrl_pkg::STEP_VEC_IR;
                    V_JUMP:  step_o = seq_ctrl_pkg::STEP_VEC_JUMP;
                    default: step_o = seq_ctrl_pkg::STEP_IDLE;
                endcase
            end
            S_READY:  step_o = seq_ctrl_pkg::STEP_DEC_NONE;  // Ready, no strobes
            S_FETCH:  step_o = seq_ctrl_pkg::STEP_FETCH;
            S_DECODE: begin
                case (instr_class_i)
                    seq_ctrl_pkg::CLS_ALU:          step_o = seq_ctrl_pkg::STEP_DEC_ALU;
                    seq_ctrl_pkg::CLS_CMP:          step_o = seq_ctrl_pkg::STEP_DEC_CMP;
                    seq_ctrl_pkg::CLS_BRANCH_TAKEN: step_o = seq_ctrl_pkg::STEP_DEC_BRANCH;
                    seq_ctrl_pkg::CLS_JMP:          step_o = seq_ctrl_pkg::STEP_DEC_JMP;
                    seq_ctrl_pkg::CLS_JPL:          step_o = seq_ctrl_pkg::STEP_DEC_JPL;
                    seq_ctrl_pkg::CLS_RET:          step_o = seq_ctrl_pkg::STEP_DEC_RET;
                    seq_ctrl_pkg::CLS_LDI:          step_o = seq_ctrl_pkg::STEP_DEC_LDI;
                    seq_ctrl_pkg::CLS_OTR:          step_o = seq_ctrl_pkg::STEP_DEC_OTR;
                    default:                        step_o = seq_ctrl_pkg::STEP_DEC_NONE;
                endcase  // NOP, HLT
            end
            S_ALU_EXEC:   step_o = seq_ctrl_pkg::STEP_WRITEBACK;
            S_BASIC_EXEC: step_o = seq_ctrl_pkg::STEP_DEC_NONE;  // Empty settle cycle
            S_HALT:       step_o = seq_ctrl_pkg::STEP_HALT;
            default:      step_o = seq_ctrl_pkg::STEP_IDLE;
        endcase
    end

endmodule

/* design/ir_field_decode.sv */
`timescale 1ns/1ps

module ir_field_decode (
    input  logic [seq_ctrl_pkg::DATA_WIDTH-1:0]   ir_i,
    input  logic [seq_ctrl_pkg::FLAG_COUNT-1:0]   alu_flags_i,
    output seq_ctrl_pkg::instr_class_t            instr_class_o,
    output logic [seq_ctrl_pkg::OPCODE_WIDTH-1:0] alu_op_o
);

    logic [seq_ctrl_pkg::OPCODE_WIDTH-1:0] opcode;
    logic                                  ignore_dest;  // CMP marker
    logic                                  zero_flag;

    // Field extraction
    assign opcode      = ir_i[seq_ctrl_pkg::DATA_WIDTH-1 -: seq_ctrl_pkg::OPCODE_WIDTH];
    assign ignore_dest = ir_i[seq_ctrl_pkg::IGNORE_DEST_BIT];
    assign zero_flag   = alu_flags_i[seq_ctrl_pkg::ZERO_FLAG_BIT];

    assign alu_op_o = opcode;  // ALU op is the opcode itself

    // ------------------------------------------------------------------------
    // Opcode and flags to instruction class
    // ------------------------------------------------------------------------
    always_comb begin
        instr_class_o = seq_ctrl_pkg::CLS_NOP;  // NOP and unlisted opcodes
        case (opcode)
            seq_ctrl_pkg::OP_ADD,
            seq_ctrl_pkg::OP_SHL,
            seq_ctrl_pkg::OP_SHR: instr_class_o = seq_ctrl_pkg::CLS_ALU;
            seq_ctrl_pkg::OP_SUB: begin
                // Flags only, no destination write
                if (ignore_dest) begin
                    instr_class_o = seq_ctrl_pkg::CLS_CMP;
                end else begin
                    instr_class_o = seq_ctrl_pkg::CLS_ALU;
                end
            end
            seq_ctrl_pkg::OP_BNE: begin
                if (!zero_flag) begin
                    instr_class_o = seq_ctrl_pkg::CLS_BRANCH_TAKEN;
                end  // Zero set falls through as NOP
            end
            seq_ctrl_pkg::OP_JMP: instr_class_o = seq_ctrl_pkg::CLS_JMP;
            seq_ctrl_pkg::OP_JPL: instr_class_o = seq_ctrl_pkg::CLS_JPL;
            seq_ctrl_pkg::OP_RET: instr_class_o = seq_ctrl_pkg::CLS_RET;
            seq_ctrl_pkg::OP_LDI: instr_class_o = seq_ctrl_pkg::CLS_LDI;
            seq_ctrl_pkg::OP_OTR: instr_class_o = seq_ctrl_pkg::CLS_OTR;
            seq_ctrl_pkg::OP_HLT: instr_class_o = seq_ctrl_pkg::CLS_HLT;
            default:              instr_class_o = seq_ctrl_pkg::CLS_NOP;
        endcase
    end

endmodule

/* design/seq_ctrl_pkg.sv */
package seq_ctrl_pkg;

    // ------------------------------------------------------------------------
    // Widths and instruction fields
    // ------------------------------------------------------------------------
    localparam int DATA_WIDTH      = 16;  // Instruction register width
    localparam int OPCODE_WIDTH    = 4;   // Opcode in the top four IR bits
    localparam int FLAG_COUNT      = 4;   // Zero, carry, negative, overflow
    localparam int ZERO_FLAG_BIT   = 0;
    localparam int IGNORE_DEST_BIT = 10;  // Marks SUB as CMP

    // ------------------------------------------------------------------------
    // Opcodes, also the ALU operation codes
    // ------------------------------------------------------------------------
    localparam logic [OPCODE_WIDTH-1:0] OP_NOP = 4'd0;
    localparam logic [OPCODE_WIDTH-1:0] OP_ADD = 4'd1;
    localparam logic [OPCODE_WIDTH-1:0] OP_SUB = 4'd2;   // CMP with bit 10 set
    localparam logic [OPCODE_WIDTH-1:0] OP_SHL = 4'd3;
    localparam logic [OPCODE_WIDTH-1:0] OP_SHR = 4'd4;
    localparam logic [OPCODE_WIDTH-1:0] OP_BNE = 4'd5;   // Branch on zero clear
    localparam logic [OPCODE_WIDTH-1:0] OP_JMP = 4'd6;
    localparam logic [OPCODE_WIDTH-1:0] OP_JPL = 4'd7;   // Jump and link
    localparam logic [OPCODE_WIDTH-1:0] OP_RET = 4'd8;
    localparam logic [OPCODE_WIDTH-1:0] OP_LDI = 4'd9;
    localparam logic [OPCODE_WIDTH-1:0] OP_OTR = 4'd10;
    localparam logic [OPCODE_WIDTH-1:0] OP_HLT = 4'd11;

    localparam logic [OPCODE_WIDTH-1:0] ALU_OP_NONE = 4'd15;  // No ALU operation

    // ------------------------------------------------------------------------
    // Datapath select codes
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        PC_SRC_BRANCH    = 3'd0,  // Sign-extended branch target
        PC_SRC_STACK     = 3'd1,  // Return address
        PC_SRC_RESET_VEC = 3'd2,
        PC_SRC_REG_SRC1  = 3'd3,
        PC_SRC_ZEXT      = 3'd4,  // Zero-extended IR low byte
        PC_SRC_IDLE      = 3'd7
    } pc_src_t;

    typedef enum logic [1:0] {
        DATA_SRC_ZEXT = 2'd0,
        DATA_SRC_ALU  = 2'd2
    } data_src_t;

    // Decoded instruction class
    typedef enum logic [3:0] {
        CLS_NOP,           // Also unlisted opcodes and untaken BNE
        CLS_ALU,
        CLS_CMP,
        CLS_BRANCH_TAKEN,
        CLS_JMP,
        CLS_JPL,
        CLS_RET,
        CLS_LDI,
        CLS_OTR,
        CLS_HLT
    } instr_class_t;

    // Action of one cycle, FSM to encoder
    typedef enum logic [3:0] {
        STEP_IDLE,        // Only while in reset
        STEP_VEC_LOAD,
        STEP_VEC_IR,
        STEP_VEC_JUMP,
        STEP_FETCH,
        STEP_DEC_NONE,    // Also ready and settle cycles
        STEP_DEC_ALU,
        STEP_DEC_CMP,
        STEP_DEC_BRANCH,
        STEP_DEC_JMP,
        STEP_DEC_JPL,
        STEP_DEC_RET,
        STEP_DEC_LDI,
        STEP_DEC_OTR,
        STEP_WRITEBACK,
        STEP_HALT
    } seq_step_t;

endpackage
